// ==== Makefile ====
TOP := tb_alu_core

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// ==== alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module alu_core (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   instr_valid,
    input  wire isa_pkg::instr_t  instr,
    output logic                  queue_almost_full,
    output logic                  queue_full,
    output logic                  illegal_instr,
    output logic                  result_valid,
    output isa_pkg::reg_idx_t     result_rd,
    output logic [31:0]           result_data
);

    logic                  push;
    logic                  pop;
    pipe_pkg::decoded_op_t dec_op;
    pipe_pkg::decoded_op_t head;
    pipe_pkg::decoded_op_t head_next;
    logic                  q_empty;
    logic                  q_empty_next;

    result_if rf_if ();

    instr_decode decode_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .push        (push),
        .op          (dec_op),
        .illegal     (illegal_instr)
    );

    issue_queue #(
        .payload_t (pipe_pkg::decoded_op_t),
        .SIZE      (`QUEUE_SIZE)
    ) queue_i (
        .clk           (clk),
        .reset         (reset),
        .push          (push),
        .pop           (pop),
        .data_in       (dec_op),
        .data_out      (head),
        .data_out_next (head_next),
        .empty         (q_empty),
        .empty_next    (q_empty_next),
        .full          (queue_full),
        .almost_full   (queue_almost_full),
        .size          ()
    );

    alu_execute execute_i (
        .clk        (clk),
        .reset      (reset),
        .head       (head),
        .head_next  (head_next),
        .empty      (q_empty),
        .empty_next (q_empty_next),
        .pop        (pop),
        .rf         (rf_if.exec)
    );

    result_writeback writeback_i (
        .clk          (clk),
        .reset        (reset),
        .rf           (rf_if.wb),
        .result_valid (result_valid),
        .result_rd    (result_rd),
        .result_data  (result_data)
    );

endmodule

`default_nettype wire

// ==== alu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module alu_execute (
    input  wire                        clk,
    input  wire                        reset,
    input  wire pipe_pkg::decoded_op_t head,
    input  wire pipe_pkg::decoded_op_t head_next,
    input  wire                        empty,
    input  wire                        empty_next,
    output logic                       pop,
    result_if.exec                     rf
);

    localparam int STEP = 32 / `MUL_CYCLES; // Multiplier bits per cycle.
    localparam int CNTW = $clog2(`MUL_CYCLES + 1);

    logic                  opnd_ok_r; // Read data matches the head.
    logic [CNTW-1:0]       mul_cnt_r;
    logic [31:0]           mul_a_r;
    logic [31:0]           mul_b_r;
    logic [31:0]           mul_acc_r;
    isa_pkg::reg_idx_t     mul_rd_r;
    logic [31:0]           mul_sum;
    logic [31:0]           alu_res;
    logic                  mul_busy;
    logic                  mul_done;
    logic                  is_mul;
    pipe_pkg::decoded_op_t rd_src;

    assign is_mul   = head.func == pipe_pkg::FUNC_MUL;
    assign mul_busy = mul_cnt_r != '0;
    assign mul_done = mul_cnt_r == CNTW'(1);
    assign pop      = !mul_busy && !empty && opnd_ok_r;

    // Address the op that will be the head next cycle.
    assign rd_src      = pop ? head_next : head;
    assign rf.rs1_addr = rd_src.rs1;
    assign rf.rs2_addr = rd_src.rs2;

    always_comb begin
        case (head.func)
            pipe_pkg::FUNC_LI:  alu_res = head.imm;
            pipe_pkg::FUNC_ADD: alu_res = rf.rs1_data + rf.rs2_data;
            pipe_pkg::FUNC_SUB: alu_res = rf.rs1_data - rf.rs2_data;
            pipe_pkg::FUNC_AND: alu_res = rf.rs1_data & rf.rs2_data;
            pipe_pkg::FUNC_OR:  alu_res = rf.rs1_data | rf.rs2_data;
            pipe_pkg::FUNC_XOR: alu_res = rf.rs1_data ^ rf.rs2_data;
            pipe_pkg::FUNC_SLT: alu_res = {31'b0, $signed(rf.rs1_data) < $signed(rf.rs2_data)};
            default:            alu_res = '0;
        endcase
    end

    // ****************************************
    // Iterative multiply, STEP bits a cycle.
    // ****************************************

    assign mul_sum = mul_acc_r + mul_a_r * {{(32 - STEP){1'b0}}, mul_b_r[STEP-1:0]};

    always_ff @(posedge clk) begin
        if (reset) begin
            opnd_ok_r <= 1'b0;
            mul_cnt_r <= '0;
        end else begin
            opnd_ok_r <= pop ? !empty_next : !empty;
            if (pop && is_mul)
                mul_cnt_r <= CNTW'(`MUL_CYCLES);
            else if (mul_busy)
                mul_cnt_r <= mul_cnt_r - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop && is_mul) begin
            mul_a_r   <= rf.rs1_data;
            mul_b_r   <= rf.rs2_data;
            mul_acc_r <= '0;
            mul_rd_r  <= head.rd;
        end else if (mul_busy) begin
            mul_a_r   <= mul_a_r << STEP;
            mul_b_r   <= mul_b_r >> STEP;
            mul_acc_r <= mul_sum;
        end
    end

    assign rf.retire_valid = (pop && !is_mul) || mul_done;
    assign rf.retire.rd    = mul_done ? mul_rd_r : head.rd;
    assign rf.retire.data  = mul_done ? mul_sum : alu_res;

    // Multiply holds the stage until it retires.
    mul_no_pop: assert property (@(posedge clk) disable iff (reset)
        pop && is_mul |=> !pop [*`MUL_CYCLES]);

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
result_if.sv
instr_decode.sv
issue_queue.sv
alu_execute.sv
result_writeback.sv
alu_core.sv
tb_alu_core.sv

// ==== instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   instr_valid,
    input  wire isa_pkg::instr_t  instr,
    output logic                  push,
    output pipe_pkg::decoded_op_t op,
    output logic                  illegal
);

    logic                valid_r;
    isa_pkg::instr_t     instr_r;
    pipe_pkg::alu_func_t func;
    logic                legal;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        instr_r <= instr;
    end

    // Opcode to ALU function.
    always_comb begin
        legal = 1'b1;
        case (instr_r.opcode)
            isa_pkg::OP_LI:  func = pipe_pkg::FUNC_LI;
            isa_pkg::OP_ADD: func = pipe_pkg::FUNC_ADD;
            isa_pkg::OP_SUB: func = pipe_pkg::FUNC_SUB;
            isa_pkg::OP_AND: func = pipe_pkg::FUNC_AND;
            isa_pkg::OP_OR:  func = pipe_pkg::FUNC_OR;
            isa_pkg::OP_XOR: func = pipe_pkg::FUNC_XOR;
            isa_pkg::OP_SLT: func = pipe_pkg::FUNC_SLT;
            isa_pkg::OP_MUL: func = pipe_pkg::FUNC_MUL;
            default: begin
                func  = pipe_pkg::FUNC_LI;
                legal = 1'b0; // Reserved opcode.
            end
        endcase
    end

    always_comb begin
        op.func = func;
        op.rd   = instr_r.rd;
        op.rs1  = instr_r.rs1;
        op.rs2  = instr_r.rs2;
        op.imm  = {{16{instr_r.imm[15]}}, instr_r.imm};
    end

    assign push    = valid_r && legal;
    assign illegal = valid_r && !legal;

endmodule

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Instruction opcodes. Codes 8 to 15 are reserved.
    typedef enum logic [3:0] {
        OP_LI  = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SLT = 4'd6,
        OP_MUL = 4'd7
    } opcode_t;

    typedef logic [3:0] reg_idx_t;

    // Instruction word, opcode in the top nibble.
    typedef struct packed {
        opcode_t            opcode;
        reg_idx_t           rd;
        reg_idx_t           rs1;
        reg_idx_t           rs2;
        logic signed [15:0] imm; // Only used by load-immediate.
    } instr_t;

endpackage

`default_nettype wire

// ==== issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module issue_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  SIZE      = 8
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       push,
    input  wire                       pop,
    input  wire payload_t             data_in,
    output payload_t                  data_out,
    output payload_t                  data_out_next,
    output logic                      empty,
    output logic                      empty_next,
    output logic                      full,
    output logic                      almost_full,
    output logic [$clog2(SIZE+1)-1:0] size
);

    localparam int ADDRW    = $clog2(SIZE);
    localparam int SIZEW    = $clog2(SIZE + 1);
    localparam int ALM_FULL = `QUEUE_ALM_FULL;

    payload_t             mem [SIZE];
    payload_t             head_r;
    payload_t             head_n;
    logic [ADDRW-1:0]     wr_ptr_r;
    logic [ADDRW-1:0]     rd_ptr_n_r; // Slot after the head.
    logic [SIZEW-1:0]     used_r;
    logic                 full_r;
    logic                 almost_full_r;
    logic                 empty_r;
    logic                 empty_n;

    // ****************************************
    // Occupancy and flags.
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            used_r        <= '0;
            full_r        <= 1'b0;
            almost_full_r <= 1'b0;
        end else begin
            case ({push, pop})
                2'b10: begin
                    used_r <= used_r + 1'b1;
                    if (used_r == SIZEW'(SIZE - 1))
                        full_r <= 1'b1;
                    if (used_r == SIZEW'(ALM_FULL - 1))
                        almost_full_r <= 1'b1;
                end
                2'b01: begin
                    used_r <= used_r - 1'b1;
                    full_r <= 1'b0;
                    if (used_r == SIZEW'(ALM_FULL))
                        almost_full_r <= 1'b0;
                end
                default: ; // Push and pop together keep the count.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_r   <= '0;
            rd_ptr_n_r <= ADDRW'(1);
        end else begin
            if (push)
                wr_ptr_r <= wr_ptr_r + 1'b1;
            if (pop)
                rd_ptr_n_r <= rd_ptr_n_r + 1'b1;
        end
    end

    // ****************************************
    // Storage and head register.
    // ****************************************

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr_r] <= data_in;
    end

    always_comb begin
        empty_n = empty_r;
        if (push && !pop)
            empty_n = 1'b0;
        else if (pop && !push && used_r == SIZEW'(1))
            empty_n = 1'b1;
    end

    // Bypass the array when the new entry becomes the head at once.
    always_comb begin
        head_n = head_r;
        if (push && (empty_r || (pop && used_r == SIZEW'(1))))
            head_n = data_in;
        else if (pop)
            head_n = mem[rd_ptr_n_r];
    end

    always_ff @(posedge clk) begin
        if (reset)
            empty_r <= 1'b1;
        else
            empty_r <= empty_n;
    end

    always_ff @(posedge clk) begin
        head_r <= head_n;
    end

    assign data_out      = head_r;
    assign data_out_next = head_n;
    assign empty         = empty_r;
    assign empty_next    = empty_n;
    assign full          = full_r;
    assign almost_full   = almost_full_r;
    assign size          = used_r;

    // The host has no back-pressure, so overflow is its error.
    push_not_full: assert property (@(posedge clk) disable iff (reset) push |-> !full_r);
    pop_not_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty_r);

endmodule

`default_nettype wire

// ==== pipe_config.svh ====
`ifndef PIPE_CONFIG_SVH
`define PIPE_CONFIG_SVH

// ****************************************
// Issue queue sizing.
// ****************************************

// Entries in the issue queue, a power of two.
`define QUEUE_SIZE 8

// Occupancy at which almost_full rises.
`define QUEUE_ALM_FULL 6

// ****************************************
// Execute and register file.
// ****************************************

`define REG_COUNT 16 // Architectural registers.

`define MUL_CYCLES 4 // Iterations of the multiplier.

`endif

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // Operation run by the execute stage.
    typedef enum logic [2:0] {
        FUNC_LI,
        FUNC_ADD,
        FUNC_SUB,
        FUNC_AND,
        FUNC_OR,
        FUNC_XOR,
        FUNC_SLT,
        FUNC_MUL
    } alu_func_t;

    // Issue queue payload.
    typedef struct packed {
        alu_func_t         func;
        isa_pkg::reg_idx_t rd;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        logic [31:0]       imm; // Already sign-extended.
    } decoded_op_t;

    // One retired result.
    typedef struct packed {
        isa_pkg::reg_idx_t rd;
        logic [31:0]       data;
    } retire_t;

endpackage

`default_nettype wire

// ==== result_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface result_if;

    // Retire path, execute to register file.
    logic              retire_valid;
    pipe_pkg::retire_t retire;

    // Operand read ports, data one cycle after the address.
    isa_pkg::reg_idx_t rs1_addr;
    isa_pkg::reg_idx_t rs2_addr;
    logic [31:0]       rs1_data;
    logic [31:0]       rs2_data;

    modport exec (
        output retire_valid,
        output retire,
        output rs1_addr,
        output rs2_addr,
        input  rs1_data,
        input  rs2_data
    );

    modport wb (
        input  retire_valid,
        input  retire,
        input  rs1_addr,
        input  rs2_addr,
        output rs1_data,
        output rs2_data
    );

endinterface

`default_nettype wire

// ==== result_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module result_writeback (
    input  wire               clk,
    input  wire               reset,
    result_if.wb              rf,
    output logic              result_valid,
    output isa_pkg::reg_idx_t result_rd,
    output logic [31:0]       result_data
);

    logic [31:0] regs [`REG_COUNT];

    // Read with bypass of a same-cycle retire. Register 0 is hardwired.
    function automatic logic [31:0] read_reg(
        input isa_pkg::reg_idx_t addr,
        input logic [31:0]       stored,
        input logic              wr_en,
        input pipe_pkg::retire_t wr
    );
        if (addr == '0)
            return '0;
        if (wr_en && wr.rd == addr)
            return wr.data;
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (rf.retire_valid && rf.retire.rd != '0) begin
            regs[rf.retire.rd] <= rf.retire.data;
        end
    end

    always_ff @(posedge clk) begin
        rf.rs1_data <= read_reg(rf.rs1_addr, regs[rf.rs1_addr], rf.retire_valid, rf.retire);
        rf.rs2_data <= read_reg(rf.rs2_addr, regs[rf.rs2_addr], rf.retire_valid, rf.retire);
    end

    // ****************************************
    // Retire report.
    // ****************************************

    always_ff @(posedge clk) begin
        if (reset)
            result_valid <= 1'b0;
        else
            result_valid <= rf.retire_valid;
    end

    always_ff @(posedge clk) begin
        result_rd   <= rf.retire.rd;
        result_data <= rf.retire.data; // Writes to r0 still report.
    end

endmodule

`default_nettype wire

// ==== tb_alu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pipe_config.svh"

module tb_alu_core;

    localparam int STALL_LIMIT = 200;
    localparam int DRAIN_LIMIT = 400;
    localparam int LAST_TEST   = 5;

    logic              clk;
    logic              reset;
    logic              instr_valid;
    isa_pkg::instr_t   instr;
    logic              queue_almost_full;
    logic              queue_full;
    logic              illegal_instr;
    logic              result_valid;
    isa_pkg::reg_idx_t result_rd;
    logic [31:0]       result_data;

    // Stimulus table, one row per instruction.
    logic [31:0] tbl_word [$];
    int          tbl_gap  [$];
    int          tbl_test [$];

    logic [31:0] model_regs [`REG_COUNT];
    logic [35:0] exp_q [$]; // {rd, data} in program order.
    int          exp_illegal;
    int          seen_illegal;
    int          errors;
    int          checks;
    bit          saw_alm_full;
    bit          timed_out;
    integer      seed;

    alu_core alu_core_i (
        .clk               (clk),
        .reset             (reset),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .queue_almost_full (queue_almost_full),
        .queue_full        (queue_full),
        .illegal_instr     (illegal_instr),
        .result_valid      (result_valid),
        .result_rd         (result_rd),
        .result_data       (result_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ****************************************
    // Table and reference model.
    // ****************************************

    task automatic add_row(input int test, input int op, input int rd, input int rs1,
                           input int rs2, input int imm, input int gap);
        tbl_word.push_back({op[3:0], rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]});
        tbl_gap.push_back(gap);
        tbl_test.push_back(test);
    endtask

    task automatic model_apply(input logic [31:0] word);
        logic [3:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        rd = word[27:24];
        a  = model_regs[word[23:20]];
        b  = model_regs[word[19:16]];
        case (word[31:28])
            4'd0: res = {{16{word[15]}}, word[15:0]};
            4'd1: res = a + b;
            4'd2: res = a - b;
            4'd3: res = a & b;
            4'd4: res = a | b;
            4'd5: res = a ^ b;
            4'd6: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4'd7: res = a * b; // Low 32 bits only.
            default: begin
                exp_illegal++;
                return;
            end
        endcase
        if (rd != 4'd0)
            model_regs[rd] = res;
        exp_q.push_back({rd, res});
    endtask

    task automatic build_table();
        int v1;
        int v2;
        int v3;
        int v4;
        v1 = $random(seed);
        v2 = $random(seed);
        v3 = $random(seed);
        v4 = $random(seed);
        // Single-cycle ops, spaced out.
        add_row(1, isa_pkg::OP_LI,  1, 0, 0, v1, 3);
        add_row(1, isa_pkg::OP_LI,  2, 0, 0, -13, 3);
        add_row(1, isa_pkg::OP_ADD, 3, 1, 2, 0, 3);
        add_row(1, isa_pkg::OP_SUB, 4, 1, 2, 0, 3);
        add_row(1, isa_pkg::OP_AND, 5, 1, 2, 0, 3);
        add_row(1, isa_pkg::OP_OR,  6, 1, 2, 0, 3);
        add_row(1, isa_pkg::OP_XOR, 7, 1, 2, 0, 3);
        add_row(1, isa_pkg::OP_SLT, 8, 2, 1, 0, 3);
        add_row(1, isa_pkg::OP_LI,  10, 0, 0, 16'h8000, 3);
        add_row(1, isa_pkg::OP_SLT, 11, 10, 2, 0, 3); // Both negative.
        // Dependent chain, back to back.
        add_row(2, isa_pkg::OP_LI,  1, 0, 0, v2, 0);
        add_row(2, isa_pkg::OP_ADD, 2, 1, 1, 0, 0);
        add_row(2, isa_pkg::OP_SUB, 3, 2, 1, 0, 0);
        add_row(2, isa_pkg::OP_XOR, 1, 3, 2, 0, 0);
        add_row(2, isa_pkg::OP_SLT, 4, 1, 3, 0, 0);
        add_row(2, isa_pkg::OP_AND, 5, 4, 1, 0, 0);
        // Multiplies fill the queue.
        add_row(3, isa_pkg::OP_LI,  5, 0, 0, v3, 0);
        add_row(3, isa_pkg::OP_LI,  6, 0, 0, v4, 0);
        add_row(3, isa_pkg::OP_MUL, 7, 5, 6, 0, 0);
        add_row(3, isa_pkg::OP_MUL, 8, 7, 5, 0, 0);
        add_row(3, isa_pkg::OP_MUL, 9, 8, 6, 0, 0);
        add_row(3, isa_pkg::OP_MUL, 10, 9, 9, 0, 0);
        add_row(3, isa_pkg::OP_ADD, 11, 10, 7, 0, 0);
        add_row(3, isa_pkg::OP_MUL, 12, 11, 6, 0, 0);
        add_row(3, isa_pkg::OP_OR,  13, 12, 5, 0, 0);
        add_row(3, isa_pkg::OP_MUL, 14, 13, 13, 0, 0);
        add_row(3, isa_pkg::OP_XOR, 15, 14, 8, 0, 0);
        add_row(3, isa_pkg::OP_MUL, 1, 15, 15, 0, 0);
        // Register 0.
        add_row(4, isa_pkg::OP_LI,  0, 0, 0, 1234, 0);
        add_row(4, isa_pkg::OP_ADD, 1, 0, 0, 0, 0);
        add_row(4, isa_pkg::OP_LI,  2, 0, 0, 7, 0);
        add_row(4, isa_pkg::OP_ADD, 3, 0, 2, 0, 0);
        add_row(4, isa_pkg::OP_MUL, 0, 2, 2, 0, 0);
        add_row(4, isa_pkg::OP_ADD, 4, 0, 2, 0, 1);
        // Reserved opcodes.
        add_row(5, isa_pkg::OP_LI,  6, 0, 0, -99, 0);
        add_row(5, 9,               6, 0, 0, 5, 0);
        add_row(5, isa_pkg::OP_ADD, 7, 6, 0, 0, 1);
        add_row(5, 15,              7, 1, 1, 0, 0);
        add_row(5, isa_pkg::OP_OR,  8, 7, 6, 0, 0);
    endtask

    // ****************************************
    // Driver, monitor and report.
    // ****************************************

    task automatic apply_row(input int idx);
        int waited;
        waited = 0;
        @(negedge clk);
        while (queue_almost_full) begin // Host stall.
            if (waited == STALL_LIMIT) begin
                $display("Timeout: queue_almost_full stayed high for %0d cycles", waited);
                errors++;
                timed_out = 1'b1;
                return;
            end
            waited++;
            @(posedge clk);
            instr_valid <= 1'b0;
            @(negedge clk);
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= isa_pkg::instr_t'(tbl_word[idx]);
        model_apply(tbl_word[idx]);
        repeat (tbl_gap[idx]) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(posedge clk);
        instr_valid <= 1'b0;
        while (exp_q.size() != 0) begin
            if (waited == DRAIN_LIMIT) begin
                $display("Timeout: %0d results never arrived", exp_q.size());
                errors++;
                timed_out = 1'b1;
                return;
            end
            waited++;
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        checks++;
        if (seen_illegal != exp_illegal) begin
            errors++;
            $display("Mismatch at %0t: %0d illegal strobes, expected %0d",
                     $time, seen_illegal, exp_illegal);
        end
    endtask

    task automatic check_idle();
        checks++;
        if (result_valid !== 1'b0 || illegal_instr !== 1'b0 || queue_full !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: strobe or queue_full high around reset", $time);
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            0:       return "reset state";
            1:       return "single-cycle ops";
            2:       return "dependent ops";
            3:       return "multiply run";
            4:       return "register 0";
            default: return "illegal opcodes";
        endcase
    endfunction

    always @(negedge clk) begin
        logic [35:0] expected;
        if (!reset) begin
            if (queue_almost_full)
                saw_alm_full = 1'b1;
            if (illegal_instr)
                seen_illegal++;
            if (result_valid) begin
                checks++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Unexpected result at %0t: r%0d = %h with nothing outstanding",
                             $time, result_rd, result_data);
                end else begin
                    expected = exp_q.pop_front();
                    if (result_rd !== expected[35:32] || result_data !== expected[31:0]) begin
                        errors++;
                        $display("Mismatch at %0t: got r%0d = %h, expected r%0d = %h", $time,
                                 result_rd, result_data, expected[35:32], expected[31:0]);
                    end
                end
            end
        end
    end

    initial begin
        int err_start;
        int row;
        seed         = 32'h6f78;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        errors       = 0;
        checks       = 0;
        exp_illegal  = 0;
        seen_illegal = 0;
        saw_alm_full = 1'b0;
        timed_out    = 1'b0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        build_table();

        err_start = errors;
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        $display("test 0 %s: %0d errors", test_name(0), errors - err_start);

        row = 0;
        for (int t = 1; t <= LAST_TEST && !timed_out; t++) begin
            err_start    = errors;
            saw_alm_full = 1'b0;
            while (row < tbl_word.size() && tbl_test[row] == t && !timed_out) begin
                apply_row(row);
                row++;
            end
            if (!timed_out)
                drain();
            if (t == 3 && !saw_alm_full) begin
                errors++;
                $display("queue_almost_full never rose during the multiply run");
            end
            $display("test %0d %s: %0d errors", t, test_name(t), errors - err_start);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
